// ==== Makefile ====
# Verilator build of the self-test sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_autotest
OBJ_DIR   ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_TEXT ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -x "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/autotest_pkg.sv ====
// Types shared by the self-test sequencer blocks, imported where a module needs them
`default_nettype none

`include "autotest_settings.svh"

package autotest_pkg;

  typedef logic [7:0] byte_t;

  // operations the sequencer asks of the storage link
  typedef enum logic [2:0] {
    OP_RESET      = 3'd0,
    OP_OPEN_READ  = 3'd1,
    OP_READ_BYTE  = 3'd2,
    OP_OPEN_WRITE = 3'd3,
    OP_WRITE_BYTE = 3'd4,
    OP_CLOSE      = 3'd5
  } storage_op_e;

  // last member sits at the lsb, so signature maps onto bytes 0 to 3
  typedef struct packed {
    logic [`AT_WORD_WIDTH-1:0] expected;
    logic [`AT_WORD_WIDTH-1:0] operand_b;
    logic [`AT_WORD_WIDTH-1:0] operand_a;
    logic [`AT_WORD_WIDTH-1:0] signature;
  } vector_fields_t;

  // written byte by byte, read field by field
  typedef union packed {
    byte_t [`AT_RECORD_BYTES-1:0] bytes;
    vector_fields_t               fields;
  } vector_rec_u;

endpackage

`default_nettype wire

// ==== hdl/autotest_settings.svh ====
// Common constants for the self-test sequencer, included by the RTL and the testbench
`ifndef AUTOTEST_SETTINGS_SVH
`define AUTOTEST_SETTINGS_SVH

// card block geometry
`define AT_BLOCK_BYTES 512
`define AT_START_BLOCK 32'h100000

// marks a valid vector block
`define AT_SIGNATURE 32'hAABBCCDD

// kept short so that simulation of a hung UUT ends quickly
`define AT_TIMEOUT_CYCLES 256

// operands, results, block address and counters
`define AT_WORD_WIDTH 32

// signature, operand a, operand b, expected result
`define AT_RECORD_BYTES 16

`endif

// ==== hdl/autotest_top.sv ====
// Top level of the self-test sequencer, SPI host and UUT on plain ports
`timescale 1ns/100ps
`default_nettype none

`include "autotest_settings.svh"

module autotest_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      start_i,
  input  wire logic                      spi_busy_i,
  output logic                           spi_rst_o,
  output logic                           spi_r_block_o,
  output logic                           spi_r_byte_o,
  output logic                           spi_w_block_o,
  output logic                           spi_w_byte_o,
  output autotest_pkg::byte_t            spi_data_in_o,
  input  wire autotest_pkg::byte_t       spi_data_out_i,
  output logic [`AT_WORD_WIDTH-1:0]      spi_block_addr_o,
  output logic                           rst_uut_o,
  input  wire logic                      end_uut_i,
  output logic [`AT_WORD_WIDTH-1:0]      operand_a_o,
  output logic [`AT_WORD_WIDTH-1:0]      operand_b_o,
  input  wire logic [`AT_WORD_WIDTH-1:0] result_i,
  output logic [`AT_WORD_WIDTH-1:0]      error_count_o,
  output logic                           done_o
);
  import autotest_pkg::*;

  vector_rec_u               record;
  logic                      sig_ok;
  logic                      load_en;
  logic [3:0]                byte_idx;
  logic                      clear_vec;
  logic                      run_req;
  logic                      run_ack;
  logic [`AT_WORD_WIDTH-1:0] run_result;
  logic [`AT_WORD_WIDTH-1:0] run_cycles;
  logic                      run_timed_out;
  logic                      run_match;
  logic                      clear_errors;

  storage_op_if st_if ();

  storage_link u_link (
    .clk            (clk),
    .rst            (rst),
    .op             (st_if.link),
    .spi_busy_i     (spi_busy_i),
    .spi_rst_o      (spi_rst_o),
    .spi_r_block_o  (spi_r_block_o),
    .spi_r_byte_o   (spi_r_byte_o),
    .spi_w_block_o  (spi_w_block_o),
    .spi_w_byte_o   (spi_w_byte_o),
    .spi_data_in_o  (spi_data_in_o),
    .spi_data_out_i (spi_data_out_i)
  );

  vector_loader u_loader (
    .clk        (clk),
    .rst        (rst),
    .clear_i    (clear_vec),
    .load_en_i  (load_en),
    .byte_idx_i (byte_idx),
    .byte_i     (st_if.rd_data),
    .record_o   (record),
    .sig_ok_o   (sig_ok)
  );

  dut_runner u_runner (
    .clk            (clk),
    .rst            (rst),
    .clear_errors_i (clear_errors),
    .run_req_i      (run_req),
    .run_ack_o      (run_ack),
    .expected_i     (record.fields.expected),
    .rst_uut_o      (rst_uut_o),
    .end_uut_i      (end_uut_i),
    .result_i       (result_i),
    .result_o       (run_result),
    .cycles_o       (run_cycles),
    .timed_out_o    (run_timed_out),
    .match_o        (run_match),
    .error_count_o  (error_count_o)
  );

  test_sequencer u_seq (
    .clk              (clk),
    .rst              (rst),
    .start_i          (start_i),
    .st               (st_if.requester),
    .spi_block_addr_o (spi_block_addr_o),
    .load_en_o        (load_en),
    .byte_idx_o       (byte_idx),
    .clear_vec_o      (clear_vec),
    .sig_ok_i         (sig_ok),
    .run_req_o        (run_req),
    .run_ack_i        (run_ack),
    .result_i         (run_result),
    .cycles_i         (run_cycles),
    .match_i          (run_match),
    .timed_out_i      (run_timed_out),
    .clear_errors_o   (clear_errors),
    .done_o           (done_o)
  );

  assign operand_a_o = record.fields.operand_a;
  assign operand_b_o = record.fields.operand_b;

endmodule

`default_nettype wire

// ==== hdl/dut_runner.sv ====
// Releases the UUT from reset for one run, times it and scores its result
`timescale 1ns/100ps
`default_nettype none

`include "autotest_settings.svh"

module dut_runner (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      clear_errors_i,
  input  wire logic                      run_req_i,
  output logic                           run_ack_o,
  input  wire logic [`AT_WORD_WIDTH-1:0] expected_i,
  output logic                           rst_uut_o,
  input  wire logic                      end_uut_i,
  input  wire logic [`AT_WORD_WIDTH-1:0] result_i,
  output logic [`AT_WORD_WIDTH-1:0]      result_o,
  output logic [`AT_WORD_WIDTH-1:0]      cycles_o,
  output logic                           timed_out_o,
  output logic                           match_o,
  output logic [`AT_WORD_WIDTH-1:0]      error_count_o
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_ACK  = 2'd2;

  logic [1:0] state_q;
  logic       timeout;
  logic       run_end;
  logic       same;

  assign timeout = (cycles_o >= `AT_TIMEOUT_CYCLES);
  assign run_end = (state_q == S_RUN) && (end_uut_i || timeout);
  assign same    = (result_i == expected_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= S_IDLE;
      rst_uut_o     <= 1'b1;
      cycles_o      <= '0;
      timed_out_o   <= 1'b0;
      match_o       <= 1'b0;
      error_count_o <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (run_req_i) begin
            state_q   <= S_RUN;
            rst_uut_o <= 1'b0;
            cycles_o  <= '0;
          end
        end
        S_RUN: begin
          if (run_end) begin
            state_q     <= S_ACK;
            rst_uut_o   <= 1'b1;
            timed_out_o <= !end_uut_i;
            match_o     <= same;
          end else begin
            cycles_o <= cycles_o + 1'b1;
          end
        end
        S_ACK:   if (!run_req_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase

      // a hung UUT is an error even if its output happens to match
      if (clear_errors_i) begin
        error_count_o <= '0;
      end else if (run_end && (!same || !end_uut_i)) begin
        error_count_o <= error_count_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run_end) begin
      result_o <= result_i;
    end
  end

  assign run_ack_o = (state_q == S_ACK);

endmodule

`default_nettype wire

// ==== hdl/storage_link.sv ====
// Runs one storage operation at a time against the SPI host busy protocol
`timescale 1ns/100ps
`default_nettype none

module storage_link (
  input  wire logic                clk,
  input  wire logic                rst,
  storage_op_if.link               op,
  input  wire logic                spi_busy_i,
  output logic                     spi_rst_o,
  output logic                     spi_r_block_o,
  output logic                     spi_r_byte_o,
  output logic                     spi_w_block_o,
  output logic                     spi_w_byte_o,
  output autotest_pkg::byte_t      spi_data_in_o,
  input  wire autotest_pkg::byte_t spi_data_out_i
);
  import autotest_pkg::*;

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_STROBE   = 3'd1;
  localparam logic [2:0] S_WAIT_LOW = 3'd2;
  localparam logic [2:0] S_SETTLE   = 3'd3;
  localparam logic [2:0] S_ACK      = 3'd4;

  logic [2:0] state_q;
  logic       r_mode_q;
  logic       w_mode_q;
  logic       strobing;
  byte_t      rd_q;
  byte_t      wr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= S_IDLE;
      r_mode_q <= 1'b0;
      w_mode_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (op.op_req) begin
            state_q <= S_STROBE;
            case (op.op_kind)
              OP_OPEN_READ:  r_mode_q <= 1'b1;
              OP_OPEN_WRITE: w_mode_q <= 1'b1;
              OP_RESET: begin
                r_mode_q <= 1'b0;
                w_mode_q <= 1'b0;
              end
              // no strobe, only let the host finish the block
              OP_CLOSE: begin
                r_mode_q <= 1'b0;
                w_mode_q <= 1'b0;
                state_q  <= S_WAIT_LOW;
              end
              default: ;
            endcase
          end
        end
        S_STROBE:   if (spi_busy_i) state_q <= S_WAIT_LOW;
        S_WAIT_LOW: if (!spi_busy_i) state_q <= S_SETTLE;
        S_SETTLE:   state_q <= S_ACK;
        S_ACK:      if (!op.op_req) state_q <= S_IDLE;
        default:    state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && op.op_req) begin
      wr_q <= op.wr_data;
    end
    // host data is valid once busy has dropped
    if (state_q == S_WAIT_LOW && !spi_busy_i && op.op_kind == OP_READ_BYTE) begin
      rd_q <= spi_data_out_i;
    end
  end

  assign strobing = (state_q == S_STROBE);

  assign spi_rst_o     = strobing && (op.op_kind == OP_RESET);
  assign spi_r_byte_o  = strobing && (op.op_kind == OP_READ_BYTE);
  assign spi_w_byte_o  = strobing && (op.op_kind == OP_WRITE_BYTE);
  // block levels double as the open strobes
  assign spi_r_block_o = r_mode_q;
  assign spi_w_block_o = w_mode_q;
  assign spi_data_in_o = wr_q;

  assign op.op_ack  = (state_q == S_ACK);
  assign op.rd_data = rd_q;

endmodule

`default_nettype wire

// ==== hdl/storage_op_if.sv ====
// Request channel from the test sequencer to the storage link, four-phase req/ack
`timescale 1ns/100ps
`default_nettype none

interface storage_op_if;
  import autotest_pkg::*;

  logic        op_req;
  storage_op_e op_kind;
  logic        op_ack;
  byte_t       wr_data;
  byte_t       rd_data;

  modport requester (
    output op_req,
    output op_kind,
    output wr_data,
    input  op_ack,
    input  rd_data
  );

  modport link (
    input  op_req,
    input  op_kind,
    input  wr_data,
    output op_ack,
    output rd_data
  );

endinterface

`default_nettype wire

// ==== hdl/test_sequencer.sv ====
// Main control of the self-test session: read a vector block, run it, write the record
`timescale 1ns/100ps
`default_nettype none

`include "autotest_settings.svh"

module test_sequencer (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      start_i,
  storage_op_if.requester                st,
  output logic [`AT_WORD_WIDTH-1:0]      spi_block_addr_o,
  output logic                           load_en_o,
  output logic [3:0]                     byte_idx_o,
  output logic                           clear_vec_o,
  input  wire logic                      sig_ok_i,
  output logic                           run_req_o,
  input  wire logic                      run_ack_i,
  input  wire logic [`AT_WORD_WIDTH-1:0] result_i,
  input  wire logic [`AT_WORD_WIDTH-1:0] cycles_i,
  input  wire logic                      match_i,
  input  wire logic                      timed_out_i,
  output logic                           clear_errors_o,
  output logic                           done_o
);
  import autotest_pkg::*;

  localparam int CNT_W = $clog2(`AT_BLOCK_BYTES);

  localparam logic [3:0] S_IDLE       = 4'd0;
  localparam logic [3:0] S_RESET_HOST = 4'd1;
  localparam logic [3:0] S_OPEN_RD    = 4'd2;
  localparam logic [3:0] S_READ       = 4'd3;
  localparam logic [3:0] S_CLOSE_RD   = 4'd4;
  localparam logic [3:0] S_CHECK      = 4'd5;
  localparam logic [3:0] S_RUN        = 4'd6;
  localparam logic [3:0] S_OPEN_WR    = 4'd7;
  localparam logic [3:0] S_WRITE      = 4'd8;
  localparam logic [3:0] S_CLOSE_WR   = 4'd9;

  // record status byte
  localparam byte_t STAT_MISMATCH = 8'h00;
  localparam byte_t STAT_MATCH    = 8'h01;
  localparam byte_t STAT_TIMEOUT  = 8'h02;

  logic [3:0]       state_q;
  logic [CNT_W-1:0] byte_cnt_q;
  logic             req_q;
  logic             op_state;
  logic             op_done;
  logic             last_byte;
  byte_t            status;
  byte_t            wr_byte;

  assign op_state  = state_q inside {S_RESET_HOST, S_OPEN_RD, S_READ, S_CLOSE_RD,
                                     S_OPEN_WR, S_WRITE, S_CLOSE_WR};
  assign op_done   = req_q && st.op_ack;
  assign last_byte = (byte_cnt_q == CNT_W'(`AT_BLOCK_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= S_IDLE;
      byte_cnt_q       <= '0;
      req_q            <= 1'b0;
      run_req_o        <= 1'b0;
      done_o           <= 1'b0;
      spi_block_addr_o <= `AT_START_BLOCK;
    end else begin
      // next request only once the link has dropped its ack
      if (op_state && !req_q && !st.op_ack) req_q <= 1'b1;
      if (op_done) req_q <= 1'b0;

      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            done_o           <= 1'b0;
            spi_block_addr_o <= `AT_START_BLOCK;
            state_q          <= S_RESET_HOST;
          end
        end
        S_RESET_HOST: if (op_done) state_q <= S_OPEN_RD;
        S_OPEN_RD, S_OPEN_WR: begin
          if (op_done) begin
            byte_cnt_q <= '0;
            state_q    <= (state_q == S_OPEN_RD) ? S_READ : S_WRITE;
          end
        end
        S_READ, S_WRITE: begin
          if (op_done) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (last_byte) state_q <= (state_q == S_READ) ? S_CLOSE_RD : S_CLOSE_WR;
          end
        end
        S_CLOSE_RD: if (op_done) state_q <= S_CHECK;
        S_CHECK: begin
          if (sig_ok_i) begin
            run_req_o <= 1'b1;
            state_q   <= S_RUN;
          end else begin
            done_o  <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        S_RUN: begin
          if (run_ack_i) begin
            run_req_o <= 1'b0;
            state_q   <= S_OPEN_WR;
          end
        end
        S_CLOSE_WR: begin
          if (op_done) begin
            spi_block_addr_o <= spi_block_addr_o + 1'b1;
            state_q          <= S_OPEN_RD;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_comb begin
    case (state_q)
      S_RESET_HOST: st.op_kind = OP_RESET;
      S_OPEN_RD:    st.op_kind = OP_OPEN_READ;
      S_READ:       st.op_kind = OP_READ_BYTE;
      S_OPEN_WR:    st.op_kind = OP_OPEN_WRITE;
      S_WRITE:      st.op_kind = OP_WRITE_BYTE;
      default:      st.op_kind = OP_CLOSE;
    endcase
  end

  assign status = timed_out_i ? STAT_TIMEOUT : (match_i ? STAT_MATCH : STAT_MISMATCH);

  // result, cycle count, status, then zero fill
  always_comb begin
    wr_byte = '0;
    if (byte_cnt_q < 4) begin
      wr_byte = result_i[{byte_cnt_q[1:0], 3'b000} +: 8];
    end else if (byte_cnt_q < 8) begin
      wr_byte = cycles_i[{byte_cnt_q[1:0], 3'b000} +: 8];
    end else if (byte_cnt_q == 8) begin
      wr_byte = status;
    end
  end

  assign st.op_req  = req_q;
  assign st.wr_data = wr_byte;

  assign load_en_o      = (state_q == S_READ) && op_done && (byte_cnt_q < `AT_RECORD_BYTES);
  assign byte_idx_o     = byte_cnt_q[3:0];
  assign clear_vec_o    = (state_q == S_OPEN_RD);
  assign clear_errors_o = (state_q == S_IDLE) && start_i;

endmodule

`default_nettype wire

// ==== hdl/vector_loader.sv ====
// Assembles the first bytes of a card block into the vector record and checks it
`timescale 1ns/100ps
`default_nettype none

`include "autotest_settings.svh"

module vector_loader (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                clear_i,
  input  wire logic                load_en_i,
  input  wire logic [3:0]          byte_idx_i,
  input  wire autotest_pkg::byte_t byte_i,
  output autotest_pkg::vector_rec_u record_o,
  output logic                     sig_ok_o
);

  // emptied before each block so a short read cannot reuse old data
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      record_o <= '0;
    end else if (load_en_i) begin
      record_o.bytes[byte_idx_i] <= byte_i;
    end
  end

  assign sig_ok_o = (record_o.fields.signature == `AT_SIGNATURE);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hdl
hdl/autotest_pkg.sv
hdl/storage_op_if.sv
hdl/storage_link.sv
hdl/vector_loader.sv
hdl/dut_runner.sv
hdl/test_sequencer.sv
hdl/autotest_top.sv
verif/autotest_assert.sv
verif/tb_autotest.sv

// ==== verif/autotest_assert.sv ====
// Handshake assertions for the self-test top level, bound into every autotest_top
`timescale 1ns/100ps
`default_nettype none

module autotest_assert (
  input wire logic clk,
  input wire logic rst,
  input wire logic spi_busy_i,
  input wire logic spi_rst_i,
  input wire logic spi_r_byte_i,
  input wire logic spi_w_byte_i,
  input wire logic spi_r_block_i,
  input wire logic spi_w_block_i,
  input wire logic run_req_i,
  input wire logic rst_uut_i
);

  logic [2:0] strobes;

  assign strobes = {spi_rst_i, spi_r_byte_i, spi_w_byte_i};

  // held until the host answers with busy
  strobe_held: assert property (@(posedge clk) disable iff (rst)
    (|strobes && !spi_busy_i) |=> (strobes == $past(strobes)))
    else $error("command strobe dropped before busy rose");

  // byte transfers only inside their own open block
  one_command: assert property (@(posedge clk) disable iff (rst)
    $onehot0({spi_rst_i, spi_r_block_i, spi_w_block_i}) &&
    !(spi_r_byte_i && !spi_r_block_i) && !(spi_w_byte_i && !spi_w_block_i))
    else $error("more than one storage command active");

  uut_held: assert property (@(posedge clk) disable iff (rst)
    !run_req_i |-> rst_uut_i)
    else $error("UUT released from reset with no run requested");

endmodule

bind autotest_top autotest_assert u_assert (
  .clk           (clk),
  .rst           (rst),
  .spi_busy_i    (spi_busy_i),
  .spi_rst_i     (spi_rst_o),
  .spi_r_byte_i  (spi_r_byte_o),
  .spi_w_byte_i  (spi_w_byte_o),
  .spi_r_block_i (spi_r_block_o),
  .spi_w_block_i (spi_w_block_o),
  .run_req_i     (run_req),
  .rst_uut_i     (rst_uut_o)
);

`default_nettype wire

// ==== verif/autotest_patterns.txt ====
// signature operand_a operand_b expected uut_result uut_delay, one card block per line
// uut_delay ff: the UUT never ends its run
aabbccdd 00000003 00000004 00000007 00000007 05
aabbccdd 12345678 00000001 12345679 12345670 0c
aabbccdd 0000beef 00001000 0000ceef 0000ceef ff
deadbeef 00000011 00000022 00000033 00000033 03

// ==== verif/tb_autotest.sv ====
// Testbench for the self-test sequencer, card, busy and UUT models fed from the pattern file
`timescale 1ns/100ps
`default_nettype none

`include "autotest_settings.svh"

module tb_autotest;
  import autotest_pkg::*;

  localparam int NUM_BLOCKS = 4;
  localparam int PAT_WORDS  = 6;
  localparam int BB         = `AT_BLOCK_BYTES;
  localparam int F_A        = 1;
  localparam int F_B        = 2;
  localparam int F_EXP      = 3;
  localparam int F_RES      = 4;
  localparam int F_DLY      = 5;
  localparam int MAX_CYCLES = 100000;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      start_i;
  logic                      spi_busy_i = 1'b0;
  logic                      spi_rst_o;
  logic                      spi_r_block_o;
  logic                      spi_r_byte_o;
  logic                      spi_w_block_o;
  logic                      spi_w_byte_o;
  byte_t                     spi_data_in_o;
  byte_t                     spi_data_out_i = '0;
  logic [`AT_WORD_WIDTH-1:0] spi_block_addr_o;
  logic                      rst_uut_o;
  logic                      end_uut_i = 1'b0;
  logic [`AT_WORD_WIDTH-1:0] operand_a_o;
  logic [`AT_WORD_WIDTH-1:0] operand_b_o;
  logic [`AT_WORD_WIDTH-1:0] result_i = '0;
  logic [`AT_WORD_WIDTH-1:0] error_count_o;
  logic                      done_o;

  logic [31:0] pat [0:NUM_BLOCKS*PAT_WORDS-1];
  byte_t       card [0:NUM_BLOCKS*BB-1];
  int          wr_count [0:NUM_BLOCKS-1];
  integer      seed = 10;
  int          busy_left;
  logic        r_block_q;
  logic        w_block_q;
  int          blk;
  int          ptr;
  int          uut_cnt;
  logic        uut_running;
  int          run_errors;
  int          runs_done;
  int          bad_idx;
  int          exp_errors;
  int          wait_cycles;
  logic        passed = 1'b0;
  logic        failed = 1'b0;
  logic [31:0] cur_vec;

  autotest_top uut (.*);

  always #10 clk = ~clk;

  // block under access
  assign cur_vec = spi_block_addr_o - `AT_START_BLOCK;

  task automatic abort_run(input string msg);
    failed = 1'b1;
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input logic [`AT_WORD_WIDTH-1:0] got,
                            input logic [`AT_WORD_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_count(input logic [`AT_WORD_WIDTH-1:0] got,
                             input logic [`AT_WORD_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // record bytes from the file, the rest a fill over the whole card address
  function automatic byte_t initial_byte(input int b, input int i);
    int addr;
    addr = b * BB + i;
    if (i < `AT_RECORD_BYTES) return byte_t'(pat[b*PAT_WORDS + i/4] >> (8 * (i % 4)));
    return byte_t'(addr ^ (addr >> 8));
  endfunction

  // mismatch or hung UUT
  function automatic logic vector_fails(input int v);
    return pat[v*PAT_WORDS+F_DLY] == 32'hff ||
           pat[v*PAT_WORDS+F_RES] != pat[v*PAT_WORDS+F_EXP];
  endfunction

  task automatic check_record(input int b);
    logic [31:0] res;
    logic [31:0] cyc;
    logic [31:0] dly;
    byte_t       status;
    int          base;
    int          i;
    base = b * BB;
    res  = pat[b*PAT_WORDS+F_RES];
    dly  = pat[b*PAT_WORDS+F_DLY];
    check_count(wr_count[b], BB, $sformatf("bytes written to block %0d", b));
    for (i = 0; i < 4; i++) begin
      check_byte(card[base+i], byte_t'(res >> (8 * i)), $sformatf("block %0d result byte %0d", b, i));
    end
    cyc = {card[base+7], card[base+6], card[base+5], card[base+4]};
    if (dly == 32'hff) begin
      status = 8'h02;
      if (cyc < `AT_TIMEOUT_CYCLES) begin
        abort_run($sformatf("Error at %0t: block %0d cycle field %0d is below the timeout",
                            $time, b, cyc));
      end
    end else begin
      status = (res == pat[b*PAT_WORDS+F_EXP]) ? 8'h01 : 8'h00;
      if (cyc < dly || cyc >= `AT_TIMEOUT_CYCLES) begin
        abort_run($sformatf("Error at %0t: block %0d cycle field %0d out of range", $time, b, cyc));
      end
    end
    check_byte(card[base+8], status, $sformatf("block %0d status byte", b));
    for (i = 9; i < BB; i++) begin
      check_byte(card[base+i], 8'h00, $sformatf("block %0d fill byte %0d", b, i));
    end
  endtask

  task automatic check_untouched(input int b);
    int i;
    check_count(wr_count[b], 0, $sformatf("bytes written to block %0d", b));
    for (i = 0; i < BB; i++) begin
      check_byte(card[b*BB+i], initial_byte(b, i), $sformatf("block %0d byte %0d", b, i));
    end
  endtask

  // SPI host and card, busy follows each command after one cycle
  always @(posedge clk) begin
    if (rst) begin
      spi_busy_i <= 1'b0;
      busy_left  <= 0;
      r_block_q  <= 1'b0;
      w_block_q  <= 1'b0;
      for (int b = 0; b < NUM_BLOCKS; b++) begin
        wr_count[b] = 0;
        for (int i = 0; i < BB; i++) card[b*BB+i] = initial_byte(b, i);
      end
    end else begin
      r_block_q <= spi_r_block_o;
      w_block_q <= spi_w_block_o;
      if (busy_left != 0) begin
        busy_left <= busy_left - 1;
        if (busy_left == 1) spi_busy_i <= 1'b0;
      end else if (spi_rst_o || spi_r_byte_o || spi_w_byte_o ||
                   (spi_r_block_o && !r_block_q) || (spi_w_block_o && !w_block_q)) begin
        spi_busy_i <= 1'b1;
        busy_left  <= 1 + ($random(seed) & 3);
        if ((spi_r_block_o && !r_block_q) || (spi_w_block_o && !w_block_q)) begin
          if (cur_vec >= NUM_BLOCKS) abort_run("Card block opened outside the modelled blocks");
          blk = cur_vec;
          ptr = 0;
        end
        if ((spi_r_byte_o || spi_w_byte_o) && ptr >= BB) begin
          abort_run("More bytes transferred than one card block holds");
        end
        if (spi_r_byte_o) begin
          spi_data_out_i <= card[blk*BB+ptr];
          ptr = ptr + 1;
        end
        if (spi_w_byte_o) begin
          card[blk*BB+ptr] = spi_data_in_o;
          wr_count[blk]    = wr_count[blk] + 1;
          ptr = ptr + 1;
        end
      end
    end
  end

  // UUT answers after the per-vector delay, ff never answers
  // runs are counted here, so the vector in use is runs_done
  always @(posedge clk) begin
    if (rst) begin
      end_uut_i   <= 1'b0;
      uut_cnt     <= 0;
      uut_running <= 1'b0;
      run_errors  = 0;
      runs_done   = 0;
    end else if (rst_uut_o) begin
      end_uut_i   <= 1'b0;
      uut_cnt     <= 0;
      uut_running <= 1'b0;
      if (uut_running) begin
        run_errors = run_errors + vector_fails(runs_done);
        check_count(error_count_o, run_errors,
                    $sformatf("error_count_o after vector %0d", runs_done));
        runs_done  = runs_done + 1;
      end
    end else begin
      uut_running <= 1'b1;
      uut_cnt     <= uut_cnt + 1;
      result_i    <= pat[runs_done*PAT_WORDS+F_RES];
      check_word(operand_a_o, pat[runs_done*PAT_WORDS+F_A], "operand_a_o during the run");
      check_word(operand_b_o, pat[runs_done*PAT_WORDS+F_B], "operand_b_o during the run");
      if (pat[runs_done*PAT_WORDS+F_DLY] != 32'hff &&
          uut_cnt == pat[runs_done*PAT_WORDS+F_DLY]) begin
        end_uut_i <= 1'b1;
      end
    end
  end

  initial begin
    rst     = 1'b1;
    start_i = 1'b0;
    $readmemh("verif/autotest_patterns.txt", pat);
    bad_idx    = NUM_BLOCKS;
    exp_errors = 0;
    for (int v = NUM_BLOCKS - 1; v >= 0; v--) begin
      if (pat[v*PAT_WORDS] != `AT_SIGNATURE) bad_idx = v;
    end
    if (bad_idx == NUM_BLOCKS) abort_run("Pattern file has no block with a wrong signature");
    for (int v = 0; v < bad_idx; v++) begin
      exp_errors = exp_errors + vector_fails(v);
    end

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // done, UUT reset and the five strobes
    check_byte({1'b0, done_o, rst_uut_o, spi_rst_o, spi_r_block_o, spi_r_byte_o,
                spi_w_block_o, spi_w_byte_o}, 8'h20, "control outputs after reset");
    check_count(error_count_o, 0, "error_count_o after reset");

    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    wait_cycles = 0;
    while (!done_o && wait_cycles < MAX_CYCLES) begin
      @(posedge clk);
      wait_cycles = wait_cycles + 1;
    end
    if (!done_o) abort_run("Timed out waiting for done_o at the end of the session");

    check_count(error_count_o, exp_errors, "final error_count_o");
    check_count(runs_done, bad_idx, "number of UUT runs");
    for (int b = 0; b < NUM_BLOCKS; b++) begin
      if (b < bad_idx) begin
        check_record(b);
      end else begin
        check_untouched(b);
      end
    end
    passed = 1'b1;
    $display("Test passed");
    $finish;
  end

  // a run stopped by a failed assertion
  final begin
    if (!passed && !failed) $display("Test failed");
  end

endmodule

`default_nettype wire
